//--- files.f
video_meas_pkg.sv
sync_blank_counter.sv
frame_settle_tracker.sv
video_timing_meter.sv
tb_raster_gen.sv
tb_video_timing_meter.sv

//--- Bender.yml
package:
  name: video_timing_meter

sources:
  - video_meas_pkg.sv
  - sync_blank_counter.sv
  - frame_settle_tracker.sv
  - video_timing_meter.sv
  - target: test
    files:
      - tb_raster_gen.sv
      - tb_video_timing_meter.sv

//--- tb_video_timing_meter.sv
/*
 * Testbench for the video timing meter
 * Random raster timing sets from an LCG, checked against a per-axis model
 */
`timescale 1ns/1ps

module tb_video_timing_meter import video_meas_pkg::*; ();

    localparam int num_tests     = 3;       // Timing sets, each after its own reset
    localparam int frame_timeout = 300000;  // Cycles allowed per frame start

    logic           clk;
    logic           rst;
    logic           pxl_cen;
    logic           lhbl;
    logic           lvbl;
    logic           hs;
    logic           vs;
    timing_report_t report;
    int             frame_cnt;              // Frame starts from the raster source

    logic [7:0]     h_act, h_bs, h_sy, h_sa;
    logic [7:0]     v_act, v_bs, v_sy, v_sa;
    axis_meas_t     exp_h;                  // Model results for current set
    axis_meas_t     exp_v;

    logic [31:0]    timing_seed;            // Stream for timing sets
    logic [31:0]    cen_seed;               // Stream for pxl_cen gaps

    video_timing_meter video_timing_meter_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hs      (hs),
        .vs      (vs),
        .report  (report)
    );

    tb_raster_gen gen_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .h_act     (h_act),
        .h_bs      (h_bs),
        .h_sy      (h_sy),
        .h_sa      (h_sa),
        .v_act     (v_act),
        .v_bs      (v_bs),
        .v_sy      (v_sy),
        .v_sa      (v_sa),
        .lhbl      (lhbl),
        .hs        (hs),
        .lvbl      (lvbl),
        .vs        (vs),
        .frame_cnt (frame_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Axis model, from active, front porch, sync and back porch lengths
    function automatic axis_meas_t expect_axis(input int act, input int bs,
                                               input int sy, input int sa);
        axis_meas_t m;
        m.total  = span_cnt_t'(act - 1);
        m.bs_len = sub_len_t'(bs);
        m.sy_len = sub_len_t'(sy - 1);
        m.sa_len = sub_len_t'(sa - 1);
        return m;
    endfunction

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_axis(input string name, input axis_meas_t got, input axis_meas_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h (total/bs/sy/sa %h/%h/%h/%h vs %h/%h/%h/%h)",
                     name, got, exp, got.total, got.bs_len, got.sy_len, got.sa_len,
                     exp.total, exp.bs_len, exp.sy_len, exp.sa_len);
            stop_with_failure();
        end
    endtask

    task automatic check_rdy(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error report.rdy: got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    // One length in [lo, hi] from the timing stream
    task automatic pick_len(input int lo, input int hi, output logic [7:0] len);
        int r;
        timing_seed = lcg_next(timing_seed);
        r           = timing_seed[31:16];   // Upper bits, better period
        len         = 8'(lo + r % (hi - lo + 1));
    endtask

    task automatic pick_timing();
        pick_len(20, 200, h_act);
        pick_len(1, 20, h_bs);
        pick_len(2, 20, h_sy);
        pick_len(2, 20, h_sa);
        pick_len(20, 200, v_act);
        pick_len(1, 20, v_bs);
        pick_len(2, 20, v_sy);
        pick_len(2, 20, v_sa);
        exp_h = expect_axis(h_act, h_bs, h_sy, h_sa);
        exp_v = expect_axis(v_act, v_bs, v_sy, v_sa);
    endtask

    // New timing set loaded while raster source and DUT sit in reset
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        pick_timing();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Checks valid on every cycle, ready and results follow frame starts
    task automatic check_cycle();
        check_rdy(report.rdy, frame_cnt >= 2);
        if (frame_cnt == 0) begin
            check_axis("report.v", report.v, '0);  // No vertical blank seen yet
        end
        if (frame_cnt >= 2) begin
            check_axis("report.h", report.h, exp_h);
            check_axis("report.v", report.v, exp_v);
        end
    endtask

    task automatic wait_frame_start(input int target);
        int n;
        n = 0;
        while ((frame_cnt < target) && (n < frame_timeout)) begin
            @(negedge clk);                 // Outputs settled mid-cycle
            check_cycle();
            n++;
        end
        if (frame_cnt < target) begin
            $display("Timeout: frame start %0d never came within %0d cycles",
                     target, frame_timeout);
            stop_with_failure();
        end
    endtask

    // pxl_cen on a random subset of cycles, never more than two idle in a row
    initial begin : cen_drive
        int idle;
        pxl_cen  = 1'b0;
        cen_seed = 32'd71 ^ 32'hffff_0000;  // Second stream from the same seed
        idle     = 0;
        forever begin
            @(posedge clk);
            #1;
            cen_seed = lcg_next(cen_seed);
            if ((idle >= 2) || cen_seed[31]) begin
                pxl_cen = 1'b1;
                idle    = 0;
            end else begin
                pxl_cen = 1'b0;
                idle++;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        timing_seed = 32'd71;
        h_act       = 8'd20;
        h_bs        = 8'd1;
        h_sy        = 8'd2;
        h_sa        = 8'd2;
        v_act       = 8'd20;
        v_bs        = 8'd1;
        v_sy        = 8'd2;
        v_sa        = 8'd2;
        exp_h       = '0;
        exp_v       = '0;

        for (int t = 0; t < num_tests; t++) begin
            apply_reset();
            $display("Set %0d: H %0d/%0d/%0d/%0d V %0d/%0d/%0d/%0d", t,
                     h_act, h_bs, h_sy, h_sa, v_act, v_bs, v_sy, v_sa);
            @(negedge clk);
            check_axis("report.h", report.h, '0);   // Cleared by reset
            check_axis("report.v", report.v, '0);
            check_rdy(report.rdy, 1'b0);
            wait_frame_start(1);            // Ready still low
            wait_frame_start(2);            // Ready rises, results valid
            wait_frame_start(3);            // Ready and results hold
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- tb_raster_gen.sv
/*
 * Raster source for the video timing meter testbench
 * Drives blank and sync from pixel and line counters with a programmable timing set
 */
`timescale 1ns/1ps

module tb_raster_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,             // Counters advance only on enabled edges
    input  logic [7:0] h_act,               // Active pixels per line
    input  logic [7:0] h_bs,                // Blank pixels before hs
    input  logic [7:0] h_sy,                // hs width in pixels
    input  logic [7:0] h_sa,                // Blank pixels after hs
    input  logic [7:0] v_act,               // Active lines per frame
    input  logic [7:0] v_bs,                // Blank lines before vs
    input  logic [7:0] v_sy,                // vs width in lines
    input  logic [7:0] v_sa,                // Blank lines after vs
    output logic       lhbl,                // High during active pixels
    output logic       hs,                  // High during horizontal sync
    output logic       lvbl,                // High during active lines
    output logic       vs,                  // High during vertical sync
    output int         frame_cnt            // Frame starts seen since reset
);

    logic [9:0] px;                         // Pixel position in line
    logic [9:0] ln;                         // Line position in frame
    logic [9:0] h_sy_start;
    logic [9:0] h_sy_end;
    logic [9:0] h_tot;
    logic [9:0] v_sy_start;
    logic [9:0] v_sy_end;
    logic [9:0] v_tot;

    // Raster layout, active first, then front porch, sync, back porch
    assign h_sy_start = h_act + h_bs;
    assign h_sy_end   = h_sy_start + h_sy;
    assign h_tot      = h_sy_end + h_sa;
    assign v_sy_start = v_act + v_bs;
    assign v_sy_end   = v_sy_start + v_sy;
    assign v_tot      = v_sy_end + v_sa;

    // Outputs held low while in reset
    assign lhbl = !rst && (px < h_act);
    assign hs   = !rst && (px >= h_sy_start) && (px < h_sy_end);
    assign lvbl = !rst && (ln < v_act);
    assign vs   = !rst && (ln >= v_sy_start) && (ln < v_sy_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            px        <= '0;
            ln        <= '0;
            frame_cnt <= 0;
        end else if (pxl_cen) begin
            if (px == h_tot - 1'b1) begin
                px <= '0;                   // End of line
                if (ln == v_tot - 1'b1) begin
                    ln <= '0;               // End of frame
                end else begin
                    ln <= ln + 1'b1;
                end
            end else begin
                px <= px + 1'b1;
            end
            // First blank pixel of the first blank line
            if ((px == h_act) && (ln == v_act)) begin
                frame_cnt <= frame_cnt + 1;
            end
        end
    end

endmodule

//--- video_timing_meter.sv
/*
 * Video timing meter top level
 * Tracker plus horizontal and vertical sync/blank counters
 */
`timescale 1ns/1ps

module video_timing_meter import video_meas_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           pxl_cen,         // Pixel clock enable
    input  logic           lhbl,            // High during active line
    input  logic           lvbl,            // High during active frame
    input  logic           hs,              // Horizontal sync, active high
    input  logic           vs,              // Vertical sync, active high
    output timing_report_t report           // Measured raster timing
);

    logic       line_stb;                   // One step per line for V
    axis_meas_t h_meas;
    axis_meas_t v_meas;

    // Line and frame tracking, report assembly
    frame_settle_tracker u_tracker (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .h_meas   (h_meas),
        .v_meas   (v_meas),
        .line_stb (line_stb),
        .report   (report)
    );

    // Horizontal axis, steps on every pixel
    sync_blank_counter u_hcnt (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .cnt_en  (1'b1),
        .sync    (hs),
        .blank_n (lhbl),
        .meas    (h_meas)
    );

    // Vertical axis, steps once per line at H blank start
    sync_blank_counter u_vcnt (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .cnt_en  (line_stb),
        .sync    (vs),
        .blank_n (lvbl),
        .meas    (v_meas)
    );

endmodule

//--- frame_settle_tracker.sv
/*
 * Frame settle tracker
 * Finds line and frame starts, counts two frames to ready and builds the report
 */
`timescale 1ns/1ps

module frame_settle_tracker import video_meas_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           pxl_cen,         // Pixel clock enable
    input  logic           lhbl,            // High during active line
    input  logic           lvbl,            // High during active frame
    input  axis_meas_t     h_meas,          // Horizontal counter results
    input  axis_meas_t     v_meas,          // Vertical counter results
    output logic           line_stb,        // Horizontal blank start
    output timing_report_t report           // Combined timing report
);

    logic          lhbl_l;                  // lhbl at previous sample
    logic          lvbl_l;                  // lvbl at previous line strobe
    logic          frame_start;
    settle_state_t state;
    settle_state_t state_nxt;

    // Falling edge of lhbl marks the start of horizontal blank
    assign line_stb    = pxl_cen && !lhbl && lhbl_l;

    // Vertical blank start, seen at a line boundary
    assign frame_start = line_stb && !lvbl && lvbl_l;

    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_l <= 1'b0;
            lvbl_l <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= lhbl;
            if (line_stb) begin
                lvbl_l <= lvbl;             // Frame level sampled once per line
            end
        end
    end

    // Settle FSM, one step per frame start
    always_comb begin
        state_nxt = state;
        if (frame_start) begin
            case (state)
                st_wait_first:  state_nxt = st_wait_second;
                st_wait_second: state_nxt = st_ready;
                st_ready:       state_nxt = st_ready;       // Sticky until reset
                default:        state_nxt = st_wait_first;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_wait_first;
        end else begin
            state <= state_nxt;
        end
    end

    // Report is a plain level
    assign report.rdy = (state == st_ready);
    assign report.h   = h_meas;
    assign report.v   = v_meas;

    line_stb_in_blank: assert property (
        @(posedge clk) disable iff (rst)
        (pxl_cen && lhbl) |-> !line_stb
    ) else $error("line_stb high while lhbl is high");

    // Once settled, only reset brings the FSM back
    ready_is_sticky: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_ready) |=> (state == st_ready)
    ) else $error("settle FSM left st_ready without reset");

endmodule

//--- sync_blank_counter.sv
/*
 * Sync/blank counter for one raster axis
 * Measures active span and the three blank sub-spans on count-enable steps
 */
`timescale 1ns/1ps

module sync_blank_counter import video_meas_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,             // Pixel clock enable
    input  logic       cnt_en,              // Step enable, 1 for H, line strobe for V
    input  logic       sync,                // Sync, high during pulse
    input  logic       blank_n,             // High during active video
    output axis_meas_t meas                 // Registered axis results
);

    span_cnt_t span_cnt;                    // Active steps since last active start
    sub_len_t  sub_cnt;                     // Blank steps since last sub-span edge
    logic      sync_l;                      // Sync level at previous step
    logic      blank_n_l;                   // Blank level at previous step

    logic      step;
    logic      act_step;
    logic      blk_step;
    logic      act_start;
    logic      sync_rise;
    logic      sync_fall;

    // Step qualification
    assign step      = pxl_cen && cnt_en;
    assign act_step  = step && blank_n;
    assign blk_step  = step && !blank_n;
    assign act_start = act_step && !blank_n_l;      // First active step after blank

    // Sync edges only count inside blank
    assign sync_rise = blk_step && sync && !sync_l;
    assign sync_fall = blk_step && !sync && sync_l;

    // Previous-step levels
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_l    <= 1'b0;
            blank_n_l <= 1'b0;
        end else if (step) begin
            sync_l    <= sync;
            blank_n_l <= blank_n;
        end
    end

    // Span counter, restarts on the first active step
    always_ff @(posedge clk) begin
        if (rst) begin
            span_cnt <= '0;
        end else if (act_start) begin
            span_cnt <= '0;
        end else if (act_step) begin
            span_cnt <= span_cnt + 1'b1;
        end
    end

    // Sub-counter, cleared at every sub-span boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            sub_cnt <= '0;
        end else if (act_start || sync_rise || sync_fall) begin
            sub_cnt <= '0;                  // New sub-span begins
        end else if (blk_step) begin
            sub_cnt <= sub_cnt + 1'b1;      // Natural wrap at 64
        end
    end

    // Result capture
    always_ff @(posedge clk) begin
        if (rst) begin
            meas <= '0;
        end else begin
            if (act_start) begin
                meas.total  <= span_cnt;    // Previous active span
                meas.sa_len <= sub_cnt;     // Back porch
            end
            if (sync_rise) begin
                meas.bs_len <= sub_cnt;     // Front porch
            end
            if (sync_fall) begin
                meas.sy_len <= sub_cnt;     // Sync width
            end
        end
    end

    // Sync width is only captured at the falling edge, never at the rising one
    sy_len_hold_on_rise: assert property (
        @(posedge clk) disable iff (rst)
        (pxl_cen && cnt_en && !blank_n && sync && !sync_l) |=> $stable(meas.sy_len)
    ) else $error("sy_len changed on a sync rising step");

endmodule

//--- video_meas_pkg.sv
/*
 * Video timing measurement shared types
 * Widths of span and sub-span counts, per-axis results, report and settle FSM
 */
package video_meas_pkg;

    // Field widths
    localparam int span_w = 9;                  // Up to 512 active pixels or lines
    localparam int sub_w  = 6;                  // Blank sub-spans up to 63 steps

    // Active span length, counted in pixels (H) or lines (V)
    typedef logic [span_w-1:0] span_cnt_t;

    // Blank sub-span length, wraps at 64
    typedef logic [sub_w-1:0] sub_len_t;

    // One axis worth of results, 27 bits
    typedef struct packed {
        span_cnt_t total;                       // Active steps minus one
        sub_len_t  bs_len;                      // Blank start to sync start
        sub_len_t  sy_len;                      // Sync length minus one
        sub_len_t  sa_len;                      // Sync end to active, minus one
    } axis_meas_t;

    // Complete timing report, 55 bits
    typedef struct packed {
        logic       rdy;                        // Two frame starts seen
        axis_meas_t h;                          // Horizontal, in pixels
        axis_meas_t v;                          // Vertical, in lines
    } timing_report_t;

    // Frame settle FSM
    typedef enum logic [1:0] {
        st_wait_first  = 2'd0,                  // No frame start yet
        st_wait_second = 2'd1,                  // One frame start seen
        st_ready       = 2'd2                   // Two or more, results valid
    } settle_state_t;

endpackage
